/* list.f */
hw/issue_pkg.sv
hw/ready_table.sv
hw/reservation_station.sv
hw/phys_regfile.sv
hw/alu_unit.sv
hw/mult_unit.sv
hw/issue_core.sv
sim/issue_core_tb.sv

/* Bender.yml */
package:
  name: issue_core

sources:
  - hw/issue_pkg.sv
  - hw/ready_table.sv
  - hw/reservation_station.sv
  - hw/phys_regfile.sv
  - hw/alu_unit.sv
  - hw/mult_unit.sv
  - hw/issue_core.sv
  - target: simulation
    files:
      - sim/issue_core_tb.sv

/* sim/issue_core_tb.sv */
`timescale 1ns/1ps

module issue_core_tb;
  import issue_pkg::*;

  logic                          clock;
  logic                          reset;
  logic                          dispatch_en;
  logic     [NUM_WAYS-1:0]       way_valid;
  fu_kind_e [NUM_WAYS-1:0]       way_kind;
  alu_op_e  [NUM_WAYS-1:0]       way_op;
  tag_t     [NUM_WAYS-1:0]       way_src1;
  tag_t     [NUM_WAYS-1:0]       way_src2;
  word_t    [NUM_WAYS-1:0]       way_imm;
  tag_t     [NUM_WAYS-1:0]       way_dest;
  rob_idx_t [NUM_WAYS-1:0]       way_rob;
  logic                          rollback_en;
  rob_idx_t                      rollback_rob;
  rob_idx_t                      rollback_span;
  logic                          dispatch_ready;
  logic     [NUM_SLOTS-1:0]      lane_valid;
  tag_t     [NUM_SLOTS-1:0]      lane_tag;
  word_t    [NUM_SLOTS-1:0]      lane_value;
  rob_idx_t [NUM_SLOTS-1:0]      lane_rob;

  word_t    model [NUM_PR];      // Expected value per tag
  rob_idx_t exp_rob [NUM_PR];
  int       exp_lane [NUM_PR];
  logic     done [NUM_PR];
  logic     rob_seen [NUM_ROB];
  tag_t     produced [$];        // Tags that hold a known value
  tag_t     next_tag;
  rob_idx_t next_rob;
  alu_op_e  chain_ops [6] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MUL};

  issue_core issue_core_i (.*);

  always #10 clock = ~clock;

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic expect_equal(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
    if (actual !== expected) begin
      $display("error at %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      stop_run();
    end
  endtask

  function automatic word_t expected_result(alu_op_e op, word_t a, word_t b, word_t imm);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_ADDI: return a + imm;
      OP_MUL:  return a * b;      // Low word only
      default: return '0;
    endcase
  endfunction

  function automatic tag_t alloc_tag();
    alloc_tag = next_tag;
    next_tag  = (next_tag == NUM_PR - 1) ? tag_t'(1) : next_tag + 1'b1;  // Skip ZERO_PR
  endfunction

  function automatic rob_idx_t alloc_rob();
    alloc_rob = next_rob;
    next_rob  = next_rob + 1'b1;
  endfunction

  function automatic tag_t pick_source();
    return produced[$urandom_range(produced.size() - 1)];
  endfunction

  function automatic fu_kind_e kind_of(alu_op_e op);
    return (op == OP_MUL) ? FU_MULT : FU_ALU;
  endfunction

  // Checks every valid lane against the model after each clock
  task automatic step();
    @(posedge clock);
    #1;
    if (!reset) begin
      for (int k = 0; k < NUM_SLOTS; k++) begin
        if (lane_valid[k]) begin
          expect_equal(k, exp_lane[lane_tag[k]], "lane index for tag");
          expect_equal(lane_value[k], model[lane_tag[k]], "lane value");
          expect_equal(lane_rob[k], exp_rob[lane_tag[k]], "lane ROB index");
          done[lane_tag[k]]    = 1'b1;
          rob_seen[lane_rob[k]] = 1'b1;
        end
      end
    end
  endtask

  task automatic set_way(input int w, input fu_kind_e kind, input alu_op_e op, input tag_t s1,
                         input tag_t s2, input word_t imm, input tag_t dest, input rob_idx_t rob);
    way_valid[w] = 1'b1;
    way_kind[w]  = kind;
    way_op[w]    = op;
    way_src1[w]  = s1;
    way_src2[w]  = s2;
    way_imm[w]   = imm;
    way_dest[w]  = dest;
    way_rob[w]   = rob;
    model[dest]    = expected_result(op, model[s1], model[s2], imm);
    exp_rob[dest]  = rob;
    exp_lane[dest] = (kind == FU_ALU) ? w : w + NUM_WAYS;
    done[dest]     = 1'b0;
  endtask

  task automatic send_bundle();
    int waited;
    waited = 0;
    #1;
    while (!dispatch_ready) begin
      if (waited == 50) begin
        $display("dispatch_ready stayed low for 50 cycles");
        stop_run();
      end
      step();
      #1;
      waited++;
    end
    dispatch_en = 1'b1;
    step();                       // Dispatch edge
    dispatch_en = 1'b0;
    way_valid   = '0;
  endtask

  task automatic wait_done(input tag_t tag, output int cycles);
    cycles = 0;
    while (!done[tag]) begin
      if (cycles == 50) begin
        $display("no lane result for tag %0d within 50 cycles", tag);
        stop_run();
      end
      step();
      cycles++;
    end
  endtask

  task automatic idle_after_reset();
    for (int combo = 0; combo < 4; combo++) begin
      way_valid   = '1;
      way_kind[0] = fu_kind_e'(combo[0]);
      way_kind[1] = fu_kind_e'(combo[1]);
      #1;
      expect_equal(dispatch_ready, 1, "dispatch_ready after reset");
      step();
    end
    way_valid = '0;
    repeat (5) begin
      step();
      expect_equal(lane_valid, 0, "lane_valid while idle");
    end
  endtask

  task automatic immediate_bundles();
    tag_t d0;
    tag_t d1;
    int   cycles;
    repeat (4) begin
      d0 = alloc_tag();
      d1 = alloc_tag();
      set_way(0, FU_ALU, OP_ADDI, ZERO_PR, ZERO_PR, $urandom, d0, alloc_rob());
      set_way(1, FU_ALU, OP_ADDI, ZERO_PR, ZERO_PR, $urandom, d1, alloc_rob());
      send_bundle();
      wait_done(d0, cycles);
      wait_done(d1, cycles);
      produced.push_back(d0);
      produced.push_back(d1);
    end
  endtask

  task automatic dependency_chains();
    alu_op_e op0;
    alu_op_e op1;
    tag_t    d0;
    tag_t    d1;
    int      cycles;
    repeat (8) begin
      op0 = chain_ops[$urandom_range(5)];
      op1 = chain_ops[$urandom_range(5)];
      d0  = alloc_tag();
      d1  = alloc_tag();
      set_way(0, kind_of(op0), op0, pick_source(), pick_source(), '0, d0, alloc_rob());
      set_way(1, kind_of(op1), op1, d0, pick_source(), '0, d1, alloc_rob());  // Same bundle
      send_bundle();
      wait_done(d0, cycles);
      wait_done(d1, cycles);
      produced.push_back(d0);
      produced.push_back(d1);
    end
  endtask

  task automatic issue_latency();
    tag_t d;
    int   cycles;
    d = alloc_tag();
    set_way(1, FU_ALU, OP_XOR, pick_source(), pick_source(), '0, d, alloc_rob());
    send_bundle();
    wait_done(d, cycles);
    expect_equal(cycles + 1, 2, "ALU cycles after dispatch edge");
    d = alloc_tag();
    set_way(0, FU_MULT, OP_MUL, pick_source(), pick_source(), '0, d, alloc_rob());
    send_bundle();
    wait_done(d, cycles);
    expect_equal(cycles + 1, 3, "MULT cycles after dispatch edge");
  endtask

  task automatic slot_full_probe();
    tag_t d0;
    tag_t d1;
    int   cycles;
    d0 = alloc_tag();
    d1 = alloc_tag();
    set_way(0, FU_MULT, OP_MUL, pick_source(), pick_source(), '0, d0, alloc_rob());
    set_way(1, FU_MULT, OP_MUL, d0, pick_source(), '0, d1, alloc_rob());
    send_bundle();
    for (int c = 0; c < 2; c++) begin
      way_valid   = 2'b10;         // Probe way 1 only
      way_kind[1] = FU_MULT;
      #1;
      expect_equal(dispatch_ready, 0, "dispatch_ready with way 1 MULT slot taken");
      way_kind[1] = FU_ALU;
      #1;
      expect_equal(dispatch_ready, 1, "dispatch_ready with way 1 ALU slot free");
      step();
    end
    way_valid = '0;
    wait_done(d0, cycles);
    wait_done(d1, cycles);
  endtask

  task automatic rollback_squash();
    tag_t d0;
    tag_t d1;
    int   cycles;
    d0 = alloc_tag();
    d1 = alloc_tag();
    set_way(0, FU_MULT, OP_MUL, pick_source(), pick_source(), '0, d0, 4'd4);
    set_way(1, FU_ALU, OP_ADD, d0, pick_source(), '0, d1, 4'd5);
    for (int r = 0; r < NUM_ROB; r++) begin
      rob_seen[r] = 1'b0;
    end
    send_bundle();
    rollback_en   = 1'b1;
    rollback_rob  = 4'd4;
    rollback_span = 4'd3;          // Squashes ROB 5 to 7
    step();
    rollback_en = 1'b0;
    wait_done(d0, cycles);
    repeat (20) step();
    expect_equal(rob_seen[5], 0, "lane with squashed ROB index 5");
  endtask

  initial begin
    void'($urandom(70));
    clock         = 1'b0;
    reset         = 1'b1;
    dispatch_en   = 1'b0;
    rollback_en   = 1'b0;
    rollback_rob  = '0;
    rollback_span = '0;
    way_valid     = '0;
    way_src1      = '0;
    way_src2      = '0;
    way_imm       = '0;
    way_dest      = '0;
    way_rob       = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_kind[w] = FU_ALU;
      way_op[w]   = OP_ADD;
    end
    for (int r = 0; r < NUM_PR; r++) begin
      model[r]    = '0;          // Register file starts at zero
      exp_rob[r]  = '0;
      exp_lane[r] = 0;
      done[r]     = 1'b0;
    end
    next_tag = 1;
    next_rob = '0;
    repeat (4) step();
    reset = 1'b0;
    idle_after_reset();
    immediate_bundles();
    dependency_chains();
    issue_latency();
    slot_full_probe();
    rollback_squash();           // Squashed tag stays busy afterwards
    $display("Test passed");
    $finish;
  end

endmodule

/* hw/issue_core.sv */
`timescale 1ns/1ps

module issue_core (
  input  logic                                            clock,
  input  logic                                            reset,
  input  logic                                            dispatch_en,
  input  logic                [issue_pkg::NUM_WAYS-1:0]   way_valid,
  input  issue_pkg::fu_kind_e [issue_pkg::NUM_WAYS-1:0]   way_kind,
  input  issue_pkg::alu_op_e  [issue_pkg::NUM_WAYS-1:0]   way_op,
  input  issue_pkg::tag_t     [issue_pkg::NUM_WAYS-1:0]   way_src1,
  input  issue_pkg::tag_t     [issue_pkg::NUM_WAYS-1:0]   way_src2,
  input  issue_pkg::word_t    [issue_pkg::NUM_WAYS-1:0]   way_imm,
  input  issue_pkg::tag_t     [issue_pkg::NUM_WAYS-1:0]   way_dest,
  input  issue_pkg::rob_idx_t [issue_pkg::NUM_WAYS-1:0]   way_rob,
  input  logic                                            rollback_en,
  input  issue_pkg::rob_idx_t                             rollback_rob,
  input  issue_pkg::rob_idx_t                             rollback_span,
  output logic                                            dispatch_ready,
  output logic                [issue_pkg::NUM_SLOTS-1:0]  lane_valid,
  output issue_pkg::tag_t     [issue_pkg::NUM_SLOTS-1:0]  lane_tag,
  output issue_pkg::word_t    [issue_pkg::NUM_SLOTS-1:0]  lane_value,
  output issue_pkg::rob_idx_t [issue_pkg::NUM_SLOTS-1:0]  lane_rob
);
  import issue_pkg::*;

  logic     [NUM_WAYS-1:0]                  src1_ready;
  logic     [NUM_WAYS-1:0]                  src2_ready;
  logic     [NUM_SLOTS-1:0]                 issue_valid;
  alu_op_e  [NUM_SLOTS-1:0]                 issue_op;
  tag_t     [NUM_SLOTS-1:0]                 issue_src1;
  tag_t     [NUM_SLOTS-1:0]                 issue_src2;
  word_t    [NUM_SLOTS-1:0]                 issue_imm;
  tag_t     [NUM_SLOTS-1:0]                 issue_dest;
  rob_idx_t [NUM_SLOTS-1:0]                 issue_rob;
  tag_t     [NUM_RD_PORTS-1:0]              rd_tag;
  word_t    [NUM_RD_PORTS-1:0]              rd_data;

  ready_table table_i (
    .clock, .reset, .way_valid, .way_src1, .way_src2, .way_dest, .dispatch_en,
    .lane_valid, .lane_tag, .src1_ready, .src2_ready
  );

  reservation_station station_i (
    .clock, .reset, .dispatch_en, .way_valid, .way_kind, .way_op, .way_src1, .way_src2,
    .src1_ready, .src2_ready, .way_imm, .way_dest, .way_rob, .lane_valid, .lane_tag,
    .rollback_en, .rollback_rob, .rollback_span, .dispatch_ready, .issue_valid,
    .issue_op, .issue_src1, .issue_src2, .issue_imm, .issue_dest, .issue_rob
  );

  // Lanes write back directly
  phys_regfile regfile_i (
    .clock, .reset, .rd_tag, .wr_valid(lane_valid), .wr_tag(lane_tag),
    .wr_data(lane_value), .rd_data
  );

  for (genvar j = 0; j < NUM_SLOTS; j++) begin : g_fu
    assign rd_tag[2*j]   = issue_src1[j];                 // Read port pair per slot
    assign rd_tag[2*j+1] = issue_src2[j];
    if (SLOT_KIND[j] == FU_ALU) begin : g_alu
      alu_unit alu_i (
        .clock, .reset, .issue_valid(issue_valid[j]), .issue_op(issue_op[j]),
        .opa(rd_data[2*j]), .opb(rd_data[2*j+1]), .imm(issue_imm[j]),
        .issue_dest(issue_dest[j]), .issue_rob(issue_rob[j]), .lane_valid(lane_valid[j]),
        .lane_tag(lane_tag[j]), .lane_value(lane_value[j]), .lane_rob(lane_rob[j])
      );
    end else begin : g_mult
      mult_unit mult_i (
        .clock, .reset, .issue_valid(issue_valid[j]), .issue_op(issue_op[j]),
        .opa(rd_data[2*j]), .opb(rd_data[2*j+1]),
        .issue_dest(issue_dest[j]), .issue_rob(issue_rob[j]), .lane_valid(lane_valid[j]),
        .lane_tag(lane_tag[j]), .lane_value(lane_value[j]), .lane_rob(lane_rob[j])
      );
    end
  end

endmodule

/* hw/mult_unit.sv */
`timescale 1ns/1ps

module mult_unit (
  input  logic                clock,
  input  logic                reset,
  input  logic                issue_valid,
  input  issue_pkg::alu_op_e  issue_op,
  input  issue_pkg::word_t    opa,
  input  issue_pkg::word_t    opb,
  input  issue_pkg::tag_t     issue_dest,
  input  issue_pkg::rob_idx_t issue_rob,
  output logic                lane_valid,
  output issue_pkg::tag_t     lane_tag,
  output issue_pkg::word_t    lane_value,
  output issue_pkg::rob_idx_t lane_rob
);
  import issue_pkg::*;

  logic     s1_valid;
  word_t    s1_prod_lo;                 // opa times low half of opb
  word_t    s1_prod_hi;                 // opa times high half of opb
  tag_t     s1_dest;
  rob_idx_t s1_rob;

  always_ff @(posedge clock) begin
    if (reset) begin
      s1_valid   <= 1'b0;
      lane_valid <= 1'b0;
    end else begin
      s1_valid   <= issue_valid && issue_op == OP_MUL;
      lane_valid <= s1_valid;
    end
  end

  always_ff @(posedge clock) begin
    s1_prod_lo <= opa * opb[XLEN/2-1:0];
    s1_prod_hi <= opa * opb[XLEN-1:XLEN/2];
    s1_dest    <= issue_dest;
    s1_rob     <= issue_rob;
    lane_value <= s1_prod_lo + (s1_prod_hi << (XLEN / 2));  // Low word of the product
    lane_tag   <= s1_dest;
    lane_rob   <= s1_rob;
  end

endmodule

/* hw/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit (
  input  logic                clock,
  input  logic                reset,
  input  logic                issue_valid,
  input  issue_pkg::alu_op_e  issue_op,
  input  issue_pkg::word_t    opa,
  input  issue_pkg::word_t    opb,
  input  issue_pkg::word_t    imm,
  input  issue_pkg::tag_t     issue_dest,
  input  issue_pkg::rob_idx_t issue_rob,
  output logic                lane_valid,
  output issue_pkg::tag_t     lane_tag,
  output issue_pkg::word_t    lane_value,
  output issue_pkg::rob_idx_t lane_rob
);
  import issue_pkg::*;

  word_t result;

  always_comb begin
    case (issue_op)
      OP_ADD:  result = opa + opb;
      OP_SUB:  result = opa - opb;
      OP_AND:  result = opa & opb;
      OP_OR:   result = opa | opb;
      OP_XOR:  result = opa ^ opb;
      OP_ADDI: result = opa + imm;     // Second source unused
      default: result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= issue_valid;
    end
  end

  always_ff @(posedge clock) begin
    lane_tag   <= issue_dest;
    lane_value <= result;
    lane_rob   <= issue_rob;
  end

endmodule

/* hw/phys_regfile.sv */
`timescale 1ns/1ps

module phys_regfile (
  input  logic                                            clock,
  input  logic                                            reset,
  input  issue_pkg::tag_t  [issue_pkg::NUM_RD_PORTS-1:0]  rd_tag,
  input  logic             [issue_pkg::NUM_SLOTS-1:0]     wr_valid,
  input  issue_pkg::tag_t  [issue_pkg::NUM_SLOTS-1:0]     wr_tag,
  input  issue_pkg::word_t [issue_pkg::NUM_SLOTS-1:0]     wr_data,
  output issue_pkg::word_t [issue_pkg::NUM_RD_PORTS-1:0]  rd_data
);
  import issue_pkg::*;

  word_t regs_q [NUM_PR];

  // Operands are read in the issue cycle
  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rd_data[p] = (rd_tag[p] == ZERO_PR) ? '0 : regs_q[rd_tag[p]];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < NUM_PR; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      for (int k = 0; k < NUM_SLOTS; k++) begin
        if (wr_valid[k] && wr_tag[k] != ZERO_PR) begin
          regs_q[wr_tag[k]] <= wr_data[k];        // One lane per unit
        end
      end
    end
  end

endmodule

/* hw/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station (
  input  logic                                           clock,
  input  logic                                           reset,
  input  logic                                           dispatch_en,
  input  logic               [issue_pkg::NUM_WAYS-1:0]   way_valid,
  input  issue_pkg::fu_kind_e [issue_pkg::NUM_WAYS-1:0]  way_kind,
  input  issue_pkg::alu_op_e [issue_pkg::NUM_WAYS-1:0]   way_op,
  input  issue_pkg::tag_t    [issue_pkg::NUM_WAYS-1:0]   way_src1,
  input  issue_pkg::tag_t    [issue_pkg::NUM_WAYS-1:0]   way_src2,
  input  logic               [issue_pkg::NUM_WAYS-1:0]   src1_ready,
  input  logic               [issue_pkg::NUM_WAYS-1:0]   src2_ready,
  input  issue_pkg::word_t   [issue_pkg::NUM_WAYS-1:0]   way_imm,
  input  issue_pkg::tag_t    [issue_pkg::NUM_WAYS-1:0]   way_dest,
  input  issue_pkg::rob_idx_t [issue_pkg::NUM_WAYS-1:0]  way_rob,
  input  logic               [issue_pkg::NUM_SLOTS-1:0]  lane_valid,
  input  issue_pkg::tag_t    [issue_pkg::NUM_SLOTS-1:0]  lane_tag,
  input  logic                                           rollback_en,
  input  issue_pkg::rob_idx_t                            rollback_rob,
  input  issue_pkg::rob_idx_t                            rollback_span,
  output logic                                           dispatch_ready,
  output logic               [issue_pkg::NUM_SLOTS-1:0]  issue_valid,
  output issue_pkg::alu_op_e [issue_pkg::NUM_SLOTS-1:0]  issue_op,
  output issue_pkg::tag_t    [issue_pkg::NUM_SLOTS-1:0]  issue_src1,
  output issue_pkg::tag_t    [issue_pkg::NUM_SLOTS-1:0]  issue_src2,
  output issue_pkg::word_t   [issue_pkg::NUM_SLOTS-1:0]  issue_imm,
  output issue_pkg::tag_t    [issue_pkg::NUM_SLOTS-1:0]  issue_dest,
  output issue_pkg::rob_idx_t [issue_pkg::NUM_SLOTS-1:0] issue_rob
);
  import issue_pkg::*;

  rs_entry_t                       slot_q [NUM_SLOTS];
  rs_entry_t                       slot_d [NUM_SLOTS];
  logic [NUM_WAYS-1:0]             alloc_hit;
  logic [NUM_WAYS-1:0][SLOT_W-1:0] alloc_idx;
  logic [NUM_SLOTS-1:0]            slot_ready;
  logic [NUM_SLOTS-1:0]            slot_squash;
  rob_idx_t                        rob_dist [NUM_SLOTS];

  // Sets the ready bit when a lane broadcasts the tag
  function automatic logic wake(src_t src);
    logic hit;
    hit = src.ready;
    for (int k = 0; k < NUM_SLOTS; k++) begin
      if (lane_valid[k] && lane_tag[k] != ZERO_PR && lane_tag[k] == src.tag) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Each way scans only its own slots, lowest first
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      alloc_hit[w] = 1'b0;
      alloc_idx[w] = '0;
      for (int j = w; j < NUM_SLOTS; j += NUM_WAYS) begin
        if (!alloc_hit[w] && !slot_q[j].busy && SLOT_KIND[j] == way_kind[w]) begin
          alloc_hit[w] = 1'b1;
          alloc_idx[w] = SLOT_W'(j);
        end
      end
    end
  end

  assign dispatch_ready = &(~way_valid | alloc_hit);

  always_comb begin
    for (int j = 0; j < NUM_SLOTS; j++) begin
      slot_ready[j]  = slot_q[j].busy && slot_q[j].src1.ready && slot_q[j].src2.ready;
      rob_dist[j]    = slot_q[j].rob - rollback_rob;       // Age relative to the rollback point
      slot_squash[j] = rollback_en && rob_dist[j] != '0 && rob_dist[j] <= rollback_span;
      issue_valid[j] = slot_ready[j];                      // Still issues during rollback
      issue_op[j]    = slot_q[j].op;
      issue_src1[j]  = slot_q[j].src1.tag;
      issue_src2[j]  = slot_q[j].src2.tag;
      issue_imm[j]   = slot_q[j].imm;
      issue_dest[j]  = slot_q[j].dest;
      issue_rob[j]   = slot_q[j].rob;
    end
  end

  always_comb begin
    slot_d = slot_q;
    for (int j = 0; j < NUM_SLOTS; j++) begin
      slot_d[j].src1.ready = wake(slot_q[j].src1);
      slot_d[j].src2.ready = wake(slot_q[j].src2);
      if (slot_ready[j] || slot_squash[j]) begin
        slot_d[j].busy = 1'b0;                             // Issued or squashed
      end
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (dispatch_en && way_valid[w] && alloc_hit[w]) begin
        slot_d[alloc_idx[w]] = '{
          busy: 1'b1,
          op:   way_op[w],
          src1: '{tag: way_src1[w], ready: src1_ready[w]},
          src2: '{tag: way_src2[w], ready: src2_ready[w] || way_op[w] == OP_ADDI},
          imm:  way_imm[w],
          dest: way_dest[w],
          rob:  way_rob[w]
        };
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int j = 0; j < NUM_SLOTS; j++) begin
        slot_q[j].busy <= 1'b0;
      end
    end else begin
      slot_q <= slot_d;
    end
  end

endmodule

/* hw/ready_table.sv */
`timescale 1ns/1ps

module ready_table (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic            [issue_pkg::NUM_WAYS-1:0]     way_valid,
  input  issue_pkg::tag_t [issue_pkg::NUM_WAYS-1:0]     way_src1,
  input  issue_pkg::tag_t [issue_pkg::NUM_WAYS-1:0]     way_src2,
  input  issue_pkg::tag_t [issue_pkg::NUM_WAYS-1:0]     way_dest,
  input  logic                                          dispatch_en,
  input  logic            [issue_pkg::NUM_SLOTS-1:0]    lane_valid,
  input  issue_pkg::tag_t [issue_pkg::NUM_SLOTS-1:0]    lane_tag,
  output logic            [issue_pkg::NUM_WAYS-1:0]     src1_ready,
  output logic            [issue_pkg::NUM_WAYS-1:0]     src2_ready
);
  import issue_pkg::*;

  logic [NUM_PR-1:0] ready_q;

  // Readiness of a source seen by way w at dispatch
  function automatic logic lookup(tag_t tag, int w);
    logic hit;
    hit = ready_q[tag];
    for (int k = 0; k < NUM_SLOTS; k++) begin
      if (lane_valid[k] && lane_tag[k] == tag) begin
        hit = 1'b1;                                 // Completion bypass
      end
    end
    for (int v = 0; v < w; v++) begin
      if (way_valid[v] && way_dest[v] == tag && tag != ZERO_PR) begin
        hit = 1'b0;                                 // Producer in same bundle
      end
    end
    return hit;
  endfunction

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      src1_ready[w] = lookup(way_src1[w], w);
      src2_ready[w] = lookup(way_src2[w], w);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_q <= '1;                                // Everything ready out of reset
    end else begin
      for (int k = 0; k < NUM_SLOTS; k++) begin
        if (lane_valid[k]) begin
          ready_q[lane_tag[k]] <= 1'b1;
        end
      end
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (dispatch_en && way_valid[w] && way_dest[w] != ZERO_PR) begin
          ready_q[way_dest[w]] <= 1'b0;             // New destination is busy
        end
      end
    end
  end

endmodule

/* hw/issue_pkg.sv */
package issue_pkg;

  localparam int NUM_WAYS     = 2;             // Dispatch width
  localparam int NUM_SLOTS    = 4;             // Station slots, units and lanes
  localparam int NUM_PR       = 32;
  localparam int NUM_ROB      = 16;
  localparam int XLEN         = 32;
  localparam int NUM_RD_PORTS = 2 * NUM_SLOTS; // Two operands per slot

  localparam int TAG_W  = $clog2(NUM_PR);
  localparam int ROB_W  = $clog2(NUM_ROB);
  localparam int SLOT_W = $clog2(NUM_SLOTS);

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [ROB_W-1:0] rob_idx_t;
  typedef logic [XLEN-1:0]  word_t;

  // Hardwired zero register, never busy
  localparam tag_t ZERO_PR = '0;

  typedef enum logic {
    FU_ALU,
    FU_MULT
  } fu_kind_e;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_MUL          // Multiplier slots only
  } alu_op_e;

  typedef struct packed {
    tag_t tag;
    logic ready;
  } src_t;

  typedef struct packed {
    logic     busy;
    alu_op_e  op;
    src_t     src1;
    src_t     src2;
    word_t    imm;
    tag_t     dest;
    rob_idx_t rob;
  } rs_entry_t;

  // Way w owns slots w and w + NUM_WAYS
  localparam fu_kind_e SLOT_KIND [NUM_SLOTS] = '{FU_ALU, FU_ALU, FU_MULT, FU_MULT};

endpackage
